/* hw/aluAddSub.sv */
`timescale 1ns/10ps
`default_nettype none

// ripple-carry adder, subtracts by inverting b and feeding a carry-in of one
module aluAddSub #(
  parameter int Width = 32
) (
  input  wire logic [Width-1:0] a,
  input  wire logic [Width-1:0] b,
  input  wire logic             subtract,
  output logic      [Width-1:0] sum,
  output logic                  carry,
  output logic                  zero,
  output logic                  overflow
);

  // b after optional inversion
  logic [Width-1:0] bInv;

  // carryChain[i] is the carry into bit i
  logic [Width:0] carryChain;

  // per-bit propagate term
  logic [Width-1:0] propagate;

  assign bInv          = b ^ {Width{subtract}};
  assign carryChain[0] = subtract;

  genvar i;
  generate
    for (i = 0; i < Width; i++) begin : gRipple
      assign propagate[i]    = a[i] ^ bInv[i];
      assign sum[i]          = propagate[i] ^ carryChain[i];
      // generate or propagate the incoming carry
      assign carryChain[i+1] = (a[i] & bInv[i]) | (propagate[i] & carryChain[i]);
    end
  endgenerate

  assign carry = carryChain[Width];

  // signed overflow when carry into and out of the msb differ
  assign overflow = carryChain[Width] ^ carryChain[Width-1];

  assign zero = ~|sum;

endmodule

`default_nettype wire

/* hw/aluCore.sv */
`timescale 1ns/10ps
`default_nettype none

module aluCore #(
  parameter int Width = 32
) (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           go,
  input  wire aluPkg::aluReqT req,
  output aluPkg::aluRspT      rsp,
  output logic                rspValid
);

  import aluPkg::*;

  // result groups behind the output mux
  localparam logic [2:0] GRP_ARITH = 3'd0;
  localparam logic [2:0] GRP_XOR   = 3'd1;
  localparam logic [2:0] GRP_SLT   = 3'd2;
  localparam logic [2:0] GRP_AND   = 3'd3;
  localparam logic [2:0] GRP_OR    = 3'd4;

  logic [2:0] grpSel;
  logic       subtract;
  logic       invert;

  wordT addSum;
  logic addCarry;
  logic addZero;
  logic addOvf;

  wordT   xorRes;
  wordT   andRes;
  wordT   orRes;
  wordT   sltRes;
  aluRspT nextRsp;

  // command decode
  always_comb begin
    grpSel   = GRP_ARITH;
    subtract = 1'b0;
    invert   = 1'b0;
    case (req.cmd)
      ADD:  grpSel = GRP_ARITH;
      SUB: begin
        grpSel   = GRP_ARITH;
        subtract = 1'b1;
      end
      XOR:  grpSel = GRP_XOR;
      // slt reuses the subtractor
      SLT: begin
        grpSel   = GRP_SLT;
        subtract = 1'b1;
      end
      AND:  grpSel = GRP_AND;
      NAND: begin
        grpSel = GRP_AND;
        invert = 1'b1;
      end
      NOR: begin
        grpSel = GRP_OR;
        invert = 1'b1;
      end
      OR:   grpSel = GRP_OR;
      default: grpSel = GRP_ARITH;
    endcase
  end

  aluAddSub #(
    .Width(Width)
  ) addSub (
    .a        (req.opA),
    .b        (req.opB),
    .subtract (subtract),
    .sum      (addSum),
    .carry    (addCarry),
    .zero     (addZero),
    .overflow (addOvf)
  );

  assign xorRes = req.opA ^ req.opB;
  assign andRes = (req.opA & req.opB) ^ {$bits(wordT){invert}};
  assign orRes  = (req.opA | req.opB) ^ {$bits(wordT){invert}};

  // signed less-than: sign of the difference corrected by overflow
  assign sltRes = {{($bits(wordT)-1){1'b0}}, addSum[$bits(wordT)-1] ^ addOvf};

  // only add and sub report flags
  always_comb begin
    nextRsp = '0;
    case (grpSel)
      GRP_ARITH: nextRsp = '{result: addSum, carry: addCarry, zero: addZero, overflow: addOvf};
      GRP_XOR:   nextRsp.result = xorRes;
      GRP_SLT:   nextRsp.result = sltRes;
      GRP_AND:   nextRsp.result = andRes;
      GRP_OR:    nextRsp.result = orRes;
      default:   nextRsp = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rspValid <= 1'b0;
    end else begin
      rspValid <= go;
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (go) begin
      rsp <= nextRsp;
    end
  end

  // the adder's zero flag agrees with the registered result
  assert property (@(posedge clk) disable iff (rst)
    rspValid && rsp.zero |-> rsp.result == '0);

endmodule

`default_nettype wire

/* hw/aluPkg.sv */
`default_nettype none

package aluPkg;

  // operand and result word
  typedef logic [31:0] wordT;

  // register byte address on the bus
  typedef logic [4:0] regAddrT;

  // AXI response code
  typedef logic [1:0] axiRespT;

  // command codes as written to the CMD register
  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    XOR  = 3'd2,
    SLT  = 3'd3,
    AND  = 3'd4,
    NAND = 3'd5,
    NOR  = 3'd6,
    OR   = 3'd7
  } aluCmdE;

  typedef struct packed {
    wordT   opA;
    wordT   opB;
    aluCmdE cmd;
  } aluReqT;

  typedef struct packed {
    wordT result;
    logic carry;
    logic zero;
    logic overflow;
  } aluRspT;

  // register map
  localparam regAddrT OPA_OFS    = 5'h00;
  localparam regAddrT OPB_OFS    = 5'h04;
  localparam regAddrT CMD_OFS    = 5'h08;
  localparam regAddrT STATUS_OFS = 5'h0C;
  localparam regAddrT RESULT_OFS = 5'h10;

  // bit positions in the status word
  localparam int DONE_BIT  = 0;
  localparam int CARRY_BIT = 1;
  localparam int ZERO_BIT  = 2;
  localparam int OVF_BIT   = 3;

  localparam axiRespT RESP_OKAY   = 2'b00;
  localparam axiRespT RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* hw/aluRegs.sv */
`timescale 1ns/10ps
`default_nettype none

module aluRegs (
  input  wire logic             clk,
  input  wire logic             rst,
  // write address and data
  input  wire aluPkg::regAddrT  awaddr,
  input  wire logic             awvalid,
  output logic                  awready,
  input  wire aluPkg::wordT     wdata,
  input  wire logic [3:0]       wstrb,
  input  wire logic             wvalid,
  output logic                  wready,
  // write response
  output aluPkg::axiRespT       bresp,
  output logic                  bvalid,
  input  wire logic             bready,
  // read address and data
  input  wire aluPkg::regAddrT  araddr,
  input  wire logic             arvalid,
  output logic                  arready,
  output aluPkg::wordT          rdata,
  output aluPkg::axiRespT       rresp,
  output logic                  rvalid,
  input  wire logic             rready,
  // core link
  output aluPkg::aluReqT        req,
  output logic                  go,
  input  wire aluPkg::aluRspT   rsp,
  input  wire logic             rspValid
);

  import aluPkg::*;

  wordT   opA;
  wordT   opB;
  aluCmdE cmd;
  wordT   resultReg;
  logic   carryReg;
  logic   zeroReg;
  logic   ovfReg;
  logic   done;

  logic wrEn;
  logic wrOk;
  logic rdEn;
  logic rdOk;
  wordT rdMux;
  wordT statusWord;

  // wstrb is ignored, every write updates the full word
  assign awready = awvalid & wvalid & ~bvalid;
  assign wready  = awready;
  assign wrEn    = awready;
  assign wrOk    = (awaddr == OPA_OFS) || (awaddr == OPB_OFS) || (awaddr == CMD_OFS);

  assign arready = ~rvalid;
  assign rdEn    = arvalid & arready;

  assign req = '{opA: opA, opB: opB, cmd: cmd};

  always_ff @(posedge clk) begin
    if (rst) begin
      opA <= '0;
      opB <= '0;
      cmd <= ADD;
      go  <= 1'b0;
    end else begin
      go <= 1'b0;
      if (wrEn) begin
        case (awaddr)
          OPA_OFS: opA <= wdata;
          OPB_OFS: opB <= wdata;
          CMD_OFS: begin
            cmd <= aluCmdE'(wdata[2:0]);
            go  <= 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  // write response channel
  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wrEn) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      bresp <= wrOk ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // done drops with the command write and returns with the response
  always_ff @(posedge clk) begin
    if (rst) begin
      resultReg <= '0;
      carryReg  <= 1'b0;
      zeroReg   <= 1'b0;
      ovfReg    <= 1'b0;
      done      <= 1'b0;
    end else if (rspValid) begin
      resultReg <= rsp.result;
      carryReg  <= rsp.carry;
      zeroReg   <= rsp.zero;
      ovfReg    <= rsp.overflow;
      done      <= 1'b1;
    end else if (wrEn && awaddr == CMD_OFS) begin
      done <= 1'b0;
    end
  end

  always_comb begin
    statusWord            = '0;
    statusWord[DONE_BIT]  = done;
    statusWord[CARRY_BIT] = carryReg;
    statusWord[ZERO_BIT]  = zeroReg;
    statusWord[OVF_BIT]   = ovfReg;
  end

  // read decode, unmapped reads return zero
  always_comb begin
    rdOk  = 1'b1;
    rdMux = '0;
    case (araddr)
      OPA_OFS:    rdMux = opA;
      OPB_OFS:    rdMux = opB;
      CMD_OFS:    rdMux = {{($bits(wordT)-$bits(aluCmdE)){1'b0}}, cmd};
      STATUS_OFS: rdMux = statusWord;
      RESULT_OFS: rdMux = resultReg;
      default:    rdOk = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (rdEn) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rdEn) begin
      rdata <= rdMux;
      rresp <= rdOk ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // responses hold steady under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp));

  assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

/* hw/aluTop.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTop #(
  parameter int Width = 32
) (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire aluPkg::regAddrT awaddr,
  input  wire logic            awvalid,
  output logic                 awready,
  input  wire aluPkg::wordT    wdata,
  input  wire logic [3:0]      wstrb,
  input  wire logic            wvalid,
  output logic                 wready,
  output aluPkg::axiRespT      bresp,
  output logic                 bvalid,
  input  wire logic            bready,
  input  wire aluPkg::regAddrT araddr,
  input  wire logic            arvalid,
  output logic                 arready,
  output aluPkg::wordT         rdata,
  output aluPkg::axiRespT      rresp,
  output logic                 rvalid,
  input  wire logic            rready
);

  import aluPkg::*;

  aluReqT req;
  logic   go;
  aluRspT rsp;
  logic   rspValid;

  aluRegs regs (
    .clk      (clk),
    .rst      (rst),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .req      (req),
    .go       (go),
    .rsp      (rsp),
    .rspValid (rspValid)
  );

  aluCore #(
    .Width(Width)
  ) core (
    .clk      (clk),
    .rst      (rst),
    .go       (go),
    .req      (req),
    .rsp      (rsp),
    .rspValid (rspValid)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status tells pass or fail
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=aluSim

verilator --binary --timing --assert -j 0 \
  --top-module aluTb \
  -f sources.f \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

/* sources.f */
hw/aluPkg.sv
hw/aluAddSub.sv
hw/aluCore.sv
hw/aluRegs.sv
hw/aluTop.sv
verif/aluTb.sv

/* verif/aluTb.sv */
`timescale 1ns/10ps
`default_nettype none

module aluTb;

  import aluPkg::*;

  // cycles any single wait may take before the run is abandoned
  localparam int TIMEOUT = 50;

  logic    clk;
  logic    rst;
  regAddrT awaddr;
  logic    awvalid;
  logic    awready;
  wordT    wdata;
  logic [3:0] wstrb;
  logic    wvalid;
  logic    wready;
  axiRespT bresp;
  logic    bvalid;
  logic    bready;
  regAddrT araddr;
  logic    arvalid;
  logic    arready;
  wordT    rdata;
  axiRespT rresp;
  logic    rvalid;
  logic    rready;

  string testName;

  aluTop #(
    .Width(32)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #20 clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s in test %s", reason, testName);
    $display("Test failures found");
    $fatal(1, "run abandoned");
  endtask

  task automatic compareWord(input string what, input wordT exp, input wordT act);
    if (exp !== act) begin
      $display("** Error in %s, %s: expected %h, actual %h", testName, what, exp, act);
      $display("Test failures found");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic compareStatus(input string what, input logic [3:0] exp, input logic [3:0] act);
    if (exp !== act) begin
      $display("** Error in %s, %s: expected %b, actual %b", testName, what, exp, act);
      $display("Test failures found");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic compareResp(input string what, input axiRespT exp, input axiRespT act);
    if (exp !== act) begin
      $display("** Error in %s, %s: expected %b, actual %b", testName, what, exp, act);
      $display("Test failures found");
      $fatal(1, "response mismatch");
    end
  endtask

  // hold keeps bready low for that many cycles once bvalid is up
  task automatic axiWrite(input regAddrT addr, input wordT data, input int hold,
                          output axiRespT resp);
    int      waitCnt;
    axiRespT firstResp;
    @(posedge clk);
    #2;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    waitCnt = 0;
    // awready is combinational, look at it well before the edge
    #1;
    while (!(awready && wready)) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) abortRun("write address and data never accepted");
      @(posedge clk);
      #3;
    end
    @(posedge clk);
    #2;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waitCnt = 0;
    while (!bvalid) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) abortRun("write response never arrived");
      @(posedge clk);
      #2;
    end
    firstResp = bresp;
    repeat (hold) begin
      @(posedge clk);
      #2;
      if (!bvalid) abortRun("bvalid dropped while bready was low");
      compareResp("bresp under back-pressure", firstResp, bresp);
    end
    bready = 1'b1;
    @(posedge clk);
    #2;
    bready = 1'b0;
    resp   = firstResp;
  endtask

  task automatic axiRead(input regAddrT addr, input int hold,
                         output wordT data, output axiRespT resp);
    int waitCnt;
    @(posedge clk);
    #2;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    waitCnt = 0;
    #1;
    while (!arready) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) abortRun("read address never accepted");
      @(posedge clk);
      #3;
    end
    @(posedge clk);
    #2;
    arvalid = 1'b0;
    waitCnt = 0;
    while (!rvalid) begin
      waitCnt++;
      if (waitCnt > TIMEOUT) abortRun("read data never arrived");
      @(posedge clk);
      #2;
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(posedge clk);
      #2;
      if (!rvalid) abortRun("rvalid dropped while rready was low");
      compareWord("rdata under back-pressure", data, rdata);
      compareResp("rresp under back-pressure", resp, rresp);
    end
    rready = 1'b1;
    @(posedge clk);
    #2;
    rready = 1'b0;
  endtask

  task automatic checkRead(input string what, input regAddrT addr, input wordT expData,
                           input axiRespT expResp);
    wordT    data;
    axiRespT resp;
    axiRead(addr, 0, data, resp);
    compareResp({what, " rresp"}, expResp, resp);
    compareWord({what, " rdata"}, expData, data);
  endtask

  task automatic checkWrite(input string what, input regAddrT addr, input wordT data,
                            input axiRespT expResp);
    axiRespT resp;
    axiWrite(addr, data, 0, resp);
    compareResp({what, " bresp"}, expResp, resp);
  endtask

  // expected result and status, straight from the ALU rules
  task automatic modelOp(input aluCmdE cmd, input wordT a, input wordT b,
                         output wordT res, output logic [3:0] status);
    logic [32:0] wide;
    logic carry;
    logic zero;
    logic ovf;
    carry = 1'b0;
    zero  = 1'b0;
    ovf   = 1'b0;
    res   = '0;
    case (cmd)
      ADD: begin
        wide  = {1'b0, a} + {1'b0, b};
        res   = wide[31:0];
        carry = wide[32];
        ovf   = (a[31] == b[31]) && (res[31] != a[31]);
        zero  = (res == '0);
      end
      SUB: begin
        // a plus inverted b plus one, carry means no borrow
        wide  = {1'b0, a} + {1'b0, ~b} + 33'd1;
        res   = wide[31:0];
        carry = wide[32];
        ovf   = (a[31] != b[31]) && (res[31] != a[31]);
        zero  = (res == '0);
      end
      XOR:  res = a ^ b;
      SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      AND:  res = a & b;
      NAND: res = ~(a & b);
      NOR:  res = ~(a | b);
      OR:   res = a | b;
      default: res = '0;
    endcase
    status            = '0;
    status[DONE_BIT]  = 1'b1;
    status[CARRY_BIT] = carry;
    status[ZERO_BIT]  = zero;
    status[OVF_BIT]   = ovf;
  endtask

  task automatic waitDone();
    wordT    data;
    axiRespT resp;
    int      polls;
    polls = 0;
    axiRead(STATUS_OFS, 0, data, resp);
    while (!data[DONE_BIT]) begin
      polls++;
      if (polls > TIMEOUT) abortRun("done never set after a command");
      axiRead(STATUS_OFS, 0, data, resp);
    end
  endtask

  task automatic runOp(input aluCmdE cmd, input wordT a, input wordT b);
    wordT       expRes;
    logic [3:0] expStatus;
    wordT       data;
    axiRespT    resp;
    modelOp(cmd, a, b, expRes, expStatus);
    checkWrite("OPA write", OPA_OFS, a, RESP_OKAY);
    checkWrite("OPB write", OPB_OFS, b, RESP_OKAY);
    checkWrite("CMD write", CMD_OFS, wordT'(cmd), RESP_OKAY);
    waitDone();
    axiRead(STATUS_OFS, 0, data, resp);
    compareStatus({cmd.name(), " status"}, expStatus, data[3:0]);
    checkRead({cmd.name(), " result"}, RESULT_OFS, expRes, RESP_OKAY);
  endtask

  task automatic resetTest();
    testName = "reset";
    checkRead("OPA", OPA_OFS, '0, RESP_OKAY);
    checkRead("OPB", OPB_OFS, '0, RESP_OKAY);
    checkRead("RESULT", RESULT_OFS, '0, RESP_OKAY);
    checkRead("STATUS", STATUS_OFS, '0, RESP_OKAY);
  endtask

  task automatic cornerTest();
    testName = "corner";
    runOp(ADD, 32'h7FFF_FFFF, 32'h0000_0001);
    runOp(ADD, 32'hFFFF_FFFF, 32'h0000_0001);
    runOp(SUB, 32'h0000_0000, 32'h0000_0001);
    runOp(SUB, 32'h0000_1234, 32'h0000_1234);
    runOp(SUB, 32'h8000_0000, 32'h0000_0001);
    runOp(XOR, 32'hA5A5_F00F, 32'h0FF0_5A5A);
    runOp(AND, 32'hA5A5_F00F, 32'h0FF0_5A5A);
    runOp(NAND, 32'hA5A5_F00F, 32'h0FF0_5A5A);
    runOp(NOR, 32'hA5A5_F00F, 32'h0FF0_5A5A);
    runOp(OR, 32'hA5A5_F00F, 32'h0FF0_5A5A);
    // slt with both signs, plus the case where the subtraction overflows
    runOp(SLT, 32'hFFFF_FFFB, 32'h0000_0003);
    runOp(SLT, 32'h0000_0003, 32'hFFFF_FFFB);
    runOp(SLT, 32'h8000_0000, 32'h7FFF_FFFF);
    runOp(SLT, 32'h0000_0042, 32'h0000_0042);
  endtask

  task automatic randomTest();
    testName = "random";
    // five rounds through all eight commands
    for (int i = 0; i < 40; i++) begin
      runOp(aluCmdE'(i[2:0]), $urandom(), $urandom());
    end
  endtask

  task automatic doneTest();
    wordT       prevRes;
    logic [3:0] prevStatus;
    wordT       expRes;
    logic [3:0] expStatus;
    wordT       data;
    axiRespT    wResp;
    axiRespT    rResp;
    testName = "done";
    runOp(ADD, 32'h1234_5678, 32'h8765_4321);
    modelOp(ADD, 32'h1234_5678, 32'h8765_4321, prevRes, prevStatus);
    modelOp(SUB, 32'h0000_0010, 32'h0000_0020, expRes, expStatus);
    checkWrite("OPA write", OPA_OFS, 32'h0000_0010, RESP_OKAY);
    checkWrite("OPB write", OPB_OFS, 32'h0000_0020, RESP_OKAY);
    // status read lands in the cycle after the command is accepted
    fork
      axiWrite(CMD_OFS, wordT'(SUB), 0, wResp);
      begin
        @(posedge clk);
        axiRead(STATUS_OFS, 0, data, rResp);
      end
    join
    compareResp("CMD write bresp", RESP_OKAY, wResp);
    prevStatus[DONE_BIT] = 1'b0;
    compareStatus("status right after CMD", prevStatus, data[3:0]);
    waitDone();
    checkRead("result", RESULT_OFS, expRes, RESP_OKAY);
    axiRead(STATUS_OFS, 0, data, rResp);
    compareStatus("status after done", expStatus, data[3:0]);
    // new operands without a command leave the result alone
    checkWrite("OPA rewrite", OPA_OFS, 32'hDEAD_BEEF, RESP_OKAY);
    checkRead("result kept", RESULT_OFS, expRes, RESP_OKAY);
  endtask

  task automatic errorTest();
    wordT       expRes;
    logic [3:0] expStatus;
    wordT       data;
    axiRespT    resp;
    testName = "error";
    runOp(XOR, 32'h0F0F_1111, 32'h00FF_2222);
    modelOp(XOR, 32'h0F0F_1111, 32'h00FF_2222, expRes, expStatus);
    checkRead("unmapped 0x14", 5'h14, '0, RESP_SLVERR);
    checkRead("unmapped 0x1C", 5'h1C, '0, RESP_SLVERR);
    checkRead("misaligned 0x01", 5'h01, '0, RESP_SLVERR);
    checkWrite("STATUS write", STATUS_OFS, 32'hFFFF_FFFF, RESP_SLVERR);
    checkWrite("RESULT write", RESULT_OFS, 32'h5555_AAAA, RESP_SLVERR);
    checkWrite("unmapped 0x18 write", 5'h18, 32'h1234_0000, RESP_SLVERR);
    checkWrite("misaligned 0x05 write", 5'h05, 32'h0000_0001, RESP_SLVERR);
    checkRead("OPA kept", OPA_OFS, 32'h0F0F_1111, RESP_OKAY);
    checkRead("OPB kept", OPB_OFS, 32'h00FF_2222, RESP_OKAY);
    checkRead("CMD kept", CMD_OFS, wordT'(XOR), RESP_OKAY);
    checkRead("RESULT kept", RESULT_OFS, expRes, RESP_OKAY);
    axiRead(STATUS_OFS, 0, data, resp);
    compareStatus("STATUS kept", expStatus, data[3:0]);
  endtask

  task automatic backPressureTest();
    wordT    data;
    axiRespT resp;
    testName = "backpressure";
    axiWrite(OPB_OFS, 32'hCAFE_0123, 5, resp);
    compareResp("held write bresp", RESP_OKAY, resp);
    axiRead(OPB_OFS, 6, data, resp);
    compareResp("held read rresp", RESP_OKAY, resp);
    compareWord("held read rdata", 32'hCAFE_0123, data);
    axiWrite(5'h14, 32'h0000_0007, 4, resp);
    compareResp("held bad write bresp", RESP_SLVERR, resp);
    axiRead(5'h14, 4, data, resp);
    compareResp("held bad read rresp", RESP_SLVERR, resp);
    compareWord("held bad read rdata", '0, data);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = 4'hF;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    testName = "init";
    void'($urandom(32'h78bf_2704));
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    resetTest();
    cornerTest();
    randomTest();
    doneTest();
    errorTest();
    backPressureTest();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
